//--- Makefile
# Verilator flow for the retirement trace unit

VERILATOR ?= verilator
TOP       ?= tb_rvfi_trace
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal -j 0
LINTFLAGS ?= --lint-only -Wall --timing
PASS_MSG  ?= Simulation PASSED

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# The run passes only if the pass message shows up in the output
run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

//--- build.f
rvfi_pkg.sv
rvfi_stage_tracker.sv
rvfi_retire_formatter.sv
rvfi_sva.sv
rvfi_apb_regs.sv
rvfi_trace_top.sv
tb_rvfi_trace.sv

//--- rvfi_apb_regs.sv
// Read-only APB slave with retirement statistics and the last mcause
// Zero wait states; writes and unmapped offsets answer with PSLVERR

`timescale 1ns/1ps

module rvfi_apb_regs
  import rvfi_pkg::*;
#(
  parameter int unsigned CNT_W = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [APB_ADDR_W-1:0]  paddr_i,
  input  logic [31:0]            pwdata_i,
  output logic [31:0]            prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o,
  input  logic                   rvfi_valid_i,
  input  logic                   rvfi_intr_i,
  input  logic [DBG_CAUSE_W-1:0] rvfi_dbg_i,
  input  logic [EXC_CAUSE_W-1:0] rvfi_mcause_i
);

  logic [CNT_W-1:0]       retired_cnt;
  logic [CNT_W-1:0]       intr_cnt;
  logic [CNT_W-1:0]       dbg_cnt;
  logic [EXC_CAUSE_W-1:0] last_cause_q;

  logic                   access;
  logic                   map_err;
  logic [31:0]            rdata;

  ////////////////////////////////////////////////////////////////////////////
  // Statistics
  ////////////////////////////////////////////////////////////////////////////

  // Counters stop at all ones rather than roll over
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      retired_cnt  <= '0;
      intr_cnt     <= '0;
      dbg_cnt      <= '0;
      last_cause_q <= '0;
    end else if (rvfi_valid_i) begin
      if (!(&retired_cnt)) retired_cnt <= retired_cnt + 1'b1;
      if (rvfi_intr_i) begin
        if (!(&intr_cnt)) intr_cnt <= intr_cnt + 1'b1;
        last_cause_q <= rvfi_mcause_i;
      end
      if ((rvfi_dbg_i != DBG_CAUSE_NONE) && !(&dbg_cnt)) dbg_cnt <= dbg_cnt + 1'b1;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // APB decode
  ////////////////////////////////////////////////////////////////////////////

  assign access = psel_i && penable_i;

  always_comb begin
    rdata   = '0;
    map_err = 1'b0;
    case (paddr_i)
      REG_RETIRED: rdata = 32'(retired_cnt);
      REG_INTR:    rdata = 32'(intr_cnt);
      REG_DBG:     rdata = 32'(dbg_cnt);
      REG_CAUSE:   rdata = 32'(last_cause_q);
      default:     map_err = 1'b1;
    endcase
  end

  // Read data is driven only for a good read, zero otherwise
  assign pready_o  = access;
  assign pslverr_o = access && (pwrite_i || map_err);
  assign prdata_o  = (access && !pwrite_i && !map_err) ? rdata : '0;

  a_penable_with_psel :
    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     penable_i |-> psel_i)
      else $error("APB penable without psel");

  // Writes are refused, but the master must still present clean data
  a_wdata_known :
    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     (access && pwrite_i) |-> !$isunknown(pwdata_i))
      else $error("APB write data unknown");

endmodule

//--- rvfi_patterns.mem
// Digits: stall, valid, exc, exc cause (two digits), irq ack, dbg ack, dbg cause
// The last four words are REG_RETIRED, REG_INTR, REG_DBG and REG_CAUSE
// Plain instructions across a two-cycle stall
01000000
01000000
01000000
10000000
10000000
01000000
// irq ack while IF is empty, taken by the next instruction
00000000
00000100
00000000
01000000
// Two debug acks, the second one during a stall
00000000
00000013
10000012
01000000
01000000
// Trap with cause 0x2A, then the handler entry
0112A000
01000000
01000000
// irq and debug ack in the cycle of entry
01000111
10000000
01000000
01000000
// Trap with cause 0x0B followed by an instruction that also takes an irq
0110B000
01000100
01000000
00000000
00000000
00000000
// Expected statistics
00000010
00000004
00000002
0000000B

//--- rvfi_pkg.sv
// Shared constants for the retirement trace unit
// Import with a wildcard in each module header that needs them

package rvfi_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Pipeline stages
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned NUM_STAGES = 4;

  // Indices into the tag shift register, oldest stage last
  localparam int unsigned STAGE_IF = 0;
  localparam int unsigned STAGE_ID = 1;
  localparam int unsigned STAGE_EX = 2;
  localparam int unsigned STAGE_WB = 3;

  ////////////////////////////////////////////////////////////////////////////
  // Trace field widths and debug causes
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned DBG_CAUSE_W = 3;
  localparam int unsigned EXC_CAUSE_W = 6;

  localparam logic [DBG_CAUSE_W-1:0] DBG_CAUSE_NONE    = 3'h0;
  localparam logic [DBG_CAUSE_W-1:0] DBG_CAUSE_EBREAK  = 3'h1;
  localparam logic [DBG_CAUSE_W-1:0] DBG_CAUSE_TRIGGER = 3'h2;
  localparam logic [DBG_CAUSE_W-1:0] DBG_CAUSE_HALTREQ = 3'h3;

  ////////////////////////////////////////////////////////////////////////////
  // APB register map
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned APB_ADDR_W = 4;

  // Byte offsets of the 32-bit statistics registers
  localparam logic [APB_ADDR_W-1:0] REG_RETIRED = 4'h0;
  localparam logic [APB_ADDR_W-1:0] REG_INTR    = 4'h4;
  localparam logic [APB_ADDR_W-1:0] REG_DBG     = 4'h8;
  localparam logic [APB_ADDR_W-1:0] REG_CAUSE   = 4'hC;

endpackage

//--- rvfi_retire_formatter.sv
// Turns the tag leaving WB into one registered retirement record and
// carries the previous trap forward into the interrupt and mcause fields

`timescale 1ns/1ps

module rvfi_retire_formatter
  import rvfi_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   shift_i,
  input  logic                   wb_valid_i,
  input  logic                   wb_intr_i,
  input  logic                   wb_exc_i,
  input  logic [DBG_CAUSE_W-1:0] wb_dbg_cause_i,
  input  logic [EXC_CAUSE_W-1:0] wb_exc_cause_i,
  output logic                   rvfi_valid_o,
  output logic                   rvfi_intr_o,
  output logic                   rvfi_trap_o,
  output logic [DBG_CAUSE_W-1:0] rvfi_dbg_o,
  output logic [EXC_CAUSE_W-1:0] rvfi_trap_cause_o,
  output logic [EXC_CAUSE_W-1:0] rvfi_mcause_o
);

  // mcause code reported for an external interrupt
  localparam logic [EXC_CAUSE_W-1:0] MCAUSE_EXT_IRQ = 6'h3F;

  logic retire;

  // A valid tag retires on the edge that pushes it out of WB
  assign retire = shift_i && wb_valid_i;

  // The trap fields hold until the next retirement, so while building a
  // record they still describe the previous one
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvfi_valid_o      <= 1'b0;
      rvfi_intr_o       <= 1'b0;
      rvfi_trap_o       <= 1'b0;
      rvfi_dbg_o        <= DBG_CAUSE_NONE;
      rvfi_trap_cause_o <= '0;
      rvfi_mcause_o     <= '0;
    end else begin
      rvfi_valid_o <= retire;
      if (retire) begin
        // The first instruction after a trap is the handler entry
        rvfi_intr_o       <= wb_intr_i || rvfi_trap_o;
        rvfi_trap_o       <= wb_exc_i;
        rvfi_dbg_o        <= wb_dbg_cause_i;
        rvfi_trap_cause_o <= wb_exc_i ? wb_exc_cause_i : '0;
        if (rvfi_trap_o) begin
          rvfi_mcause_o <= rvfi_trap_cause_o;
        end else if (wb_intr_i) begin
          rvfi_mcause_o <= MCAUSE_EXT_IRQ;
        end
      end
    end
  end

endmodule

//--- rvfi_stage_tracker.sv
// Follows each instruction tag from IF to WB and attaches pending
// interrupt and debug acknowledges to the next instruction that enters IF

`timescale 1ns/1ps

module rvfi_stage_tracker
  import rvfi_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   stall_i,
  input  logic                   instr_valid_i,
  input  logic                   exc_i,
  input  logic [EXC_CAUSE_W-1:0] exc_cause_i,
  input  logic                   irq_ack_i,
  input  logic                   dbg_ack_i,
  input  logic [DBG_CAUSE_W-1:0] dbg_cause_i,
  output logic                   wb_valid_o,
  output logic                   wb_intr_o,
  output logic                   wb_exc_o,
  output logic [DBG_CAUSE_W-1:0] wb_dbg_cause_o,
  output logic [EXC_CAUSE_W-1:0] wb_exc_cause_o,
  output logic                   shift_o
);

  // One tag per stage, indexed by the STAGE_* constants
  logic [NUM_STAGES-1:0]                  valid_q;
  logic [NUM_STAGES-1:0]                  intr_q;
  logic [NUM_STAGES-1:0]                  exc_q;
  logic [NUM_STAGES-1:0][DBG_CAUSE_W-1:0] dbg_q;
  logic [NUM_STAGES-1:0][EXC_CAUSE_W-1:0] exc_cause_q;

  // Acknowledges waiting for an instruction to land on
  logic                   irq_pend_q;
  logic                   dbg_pend_q;
  logic [DBG_CAUSE_W-1:0] dbg_cause_q;

  logic                   shift;
  logic                   enter;
  logic                   entry_intr;
  logic [DBG_CAUSE_W-1:0] entry_dbg;

  assign shift = !stall_i;
  assign enter = shift && instr_valid_i;

  // An acknowledge in the cycle of entry goes straight onto the entering tag
  assign entry_intr = irq_ack_i || irq_pend_q;

  always_comb begin
    if (dbg_ack_i) begin
      entry_dbg = dbg_cause_i;
    end else if (dbg_pend_q) begin
      entry_dbg = dbg_cause_q;
    end else begin
      entry_dbg = DBG_CAUSE_NONE;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Pending flags
  ////////////////////////////////////////////////////////////////////////////

  // Flags clear when a valid instruction takes them, and are set by an ack
  // in any other cycle, stalled or not
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_pend_q <= 1'b0;
      dbg_pend_q <= 1'b0;
    end else if (enter) begin
      irq_pend_q <= 1'b0;
      dbg_pend_q <= 1'b0;
    end else begin
      if (irq_ack_i) irq_pend_q <= 1'b1;
      if (dbg_ack_i) dbg_pend_q <= 1'b1;
    end
  end

  // A later debug ack replaces the cause of one still pending
  always_ff @(posedge clk_i) begin
    if (dbg_ack_i) begin
      dbg_cause_q <= dbg_cause_i;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Tag shift register
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
      intr_q  <= '0;
      exc_q   <= '0;
      dbg_q   <= '0;
    end else if (shift) begin
      // A bubble enters IF with every flag low
      valid_q[STAGE_IF] <= instr_valid_i;
      intr_q[STAGE_IF]  <= enter && entry_intr;
      exc_q[STAGE_IF]   <= enter && exc_i;
      dbg_q[STAGE_IF]   <= enter ? entry_dbg : DBG_CAUSE_NONE;
      for (int s = STAGE_ID; s <= STAGE_WB; s++) begin
        valid_q[s] <= valid_q[s-1];
        intr_q[s]  <= intr_q[s-1];
        exc_q[s]   <= exc_q[s-1];
        dbg_q[s]   <= dbg_q[s-1];
      end
    end
  end

  // Exception causes shift along with their tags
  always_ff @(posedge clk_i) begin
    if (shift) begin
      exc_cause_q[STAGE_IF] <= exc_cause_i;
      for (int s = STAGE_ID; s <= STAGE_WB; s++) begin
        exc_cause_q[s] <= exc_cause_q[s-1];
      end
    end
  end

  assign wb_valid_o     = valid_q[STAGE_WB];
  assign wb_intr_o      = intr_q[STAGE_WB];
  assign wb_exc_o       = exc_q[STAGE_WB];
  assign wb_dbg_cause_o = dbg_q[STAGE_WB];
  assign wb_exc_cause_o = exc_cause_q[STAGE_WB];
  assign shift_o        = shift;

  // A stalled cycle leaves every tag where it was on the next edge
  a_tags_hold_on_stall :
    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     stall_i |=> $stable(valid_q) && $stable(intr_q) &&
                                 $stable(exc_q) && $stable(dbg_q))
      else $error("Pipeline tags moved during a stall");

endmodule

//--- rvfi_sva.sv
// Checker for the trace ordering rules between acknowledges, traps and
// retirements, instantiated in the top level next to the formatter

`timescale 1ns/1ps

module rvfi_sva
  import rvfi_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,
  input  logic                   irq_ack_i,
  input  logic                   dbg_ack_i,
  input  logic                   rvfi_valid_i,
  input  logic                   rvfi_intr_i,
  input  logic                   rvfi_trap_i,
  input  logic [DBG_CAUSE_W-1:0] rvfi_dbg_i,
  input  logic [EXC_CAUSE_W-1:0] rvfi_trap_cause_i,
  input  logic [EXC_CAUSE_W-1:0] rvfi_mcause_i
);

  localparam int unsigned OUT_CNT_W = 4;

  logic [OUT_CNT_W-1:0]   irq_out_cnt;
  logic [OUT_CNT_W-1:0]   dbg_out_cnt;
  logic [2:0]             irq_age_q;
  logic                   trap_q;
  logic [EXC_CAUSE_W-1:0] trap_cause_q;
  logic                   irq_dec;
  logic                   dbg_retire;

  // Any interrupt retirement settles an outstanding irq ack, traps included
  assign irq_dec    = rvfi_valid_i && rvfi_intr_i && (irq_out_cnt != '0);
  assign dbg_retire = rvfi_valid_i && (rvfi_dbg_i != DBG_CAUSE_NONE);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      irq_out_cnt  <= '0;
      dbg_out_cnt  <= '0;
      irq_age_q    <= '0;
      trap_q       <= 1'b0;
      trap_cause_q <= '0;
    end else begin
      if (irq_ack_i && !irq_dec) irq_out_cnt <= irq_out_cnt + 1'b1;
      else if (irq_dec && !irq_ack_i) irq_out_cnt <= irq_out_cnt - 1'b1;
      if (dbg_ack_i && !dbg_retire) dbg_out_cnt <= dbg_out_cnt + 1'b1;
      else if (dbg_retire && !dbg_ack_i) dbg_out_cnt <= dbg_out_cnt - 1'b1;
      // Retirements without an interrupt while an irq ack is outstanding
      if ((irq_out_cnt == '0) || (rvfi_valid_i && rvfi_intr_i)) begin
        irq_age_q <= '0;
      end else if (rvfi_valid_i && (irq_age_q != '1)) begin
        irq_age_q <= irq_age_q + 1'b1;
      end
      if (rvfi_valid_i) begin
        trap_q       <= rvfi_trap_i;
        trap_cause_q <= rvfi_trap_cause_i;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Ordering rules
  ////////////////////////////////////////////////////////////////////////////

  a_dbg_needs_ack :
    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     dbg_retire |-> (dbg_out_cnt != '0))
      else $error("Debug retirement without an outstanding dbg_ack");

  // Only the instructions already in flight may retire ahead of the one
  // that took the acknowledge
  a_irq_ack_reaches_retire :
    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     (irq_out_cnt != '0) |-> (irq_age_q <= NUM_STAGES))
      else $error("irq_ack not followed by an interrupt retirement");

  a_trap_then_intr :
    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     (rvfi_valid_i && trap_q) |->
                     rvfi_intr_i && (rvfi_mcause_i == trap_cause_q))
      else $error("Trap not followed by an interrupt with matching mcause");

  a_cnt_no_wrap :
    assert property (@(posedge clk_i) disable iff (!rst_ni)
                     !((irq_ack_i && !irq_dec && (&irq_out_cnt)) ||
                       (dbg_ack_i && !dbg_retire && (&dbg_out_cnt))))
      else $error("Outstanding acknowledge counter wrapped");

endmodule

//--- rvfi_trace_top.sv
// Top level of the retirement trace unit that joins the tracker, formatter,
// checker and APB statistics block and brings the RVFI record out as outputs

`timescale 1ns/1ps

module rvfi_trace_top
  import rvfi_pkg::*;
#(
  parameter int unsigned CNT_W = 16
) (
  input  logic                   clk_i,
  input  logic                   rst_ni,
  // Pipeline events
  input  logic                   stall_i,
  input  logic                   instr_valid_i,
  input  logic                   exc_i,
  input  logic [EXC_CAUSE_W-1:0] exc_cause_i,
  input  logic                   irq_ack_i,
  input  logic                   dbg_ack_i,
  input  logic [DBG_CAUSE_W-1:0] dbg_cause_i,
  // Retirement record
  output logic                   rvfi_valid_o,
  output logic                   rvfi_intr_o,
  output logic                   rvfi_trap_o,
  output logic [DBG_CAUSE_W-1:0] rvfi_dbg_o,
  output logic [EXC_CAUSE_W-1:0] rvfi_trap_cause_o,
  output logic [EXC_CAUSE_W-1:0] rvfi_mcause_o,
  // APB slave
  input  logic                   psel_i,
  input  logic                   penable_i,
  input  logic                   pwrite_i,
  input  logic [APB_ADDR_W-1:0]  paddr_i,
  input  logic [31:0]            pwdata_i,
  output logic [31:0]            prdata_o,
  output logic                   pready_o,
  output logic                   pslverr_o
);

  // WB tag handed from the tracker to the formatter
  logic                   wb_valid;
  logic                   wb_intr;
  logic                   wb_exc;
  logic [DBG_CAUSE_W-1:0] wb_dbg_cause;
  logic [EXC_CAUSE_W-1:0] wb_exc_cause;
  logic                   shift;

  rvfi_stage_tracker u_tracker (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .stall_i        (stall_i),
    .instr_valid_i  (instr_valid_i),
    .exc_i          (exc_i),
    .exc_cause_i    (exc_cause_i),
    .irq_ack_i      (irq_ack_i),
    .dbg_ack_i      (dbg_ack_i),
    .dbg_cause_i    (dbg_cause_i),
    .wb_valid_o     (wb_valid),
    .wb_intr_o      (wb_intr),
    .wb_exc_o       (wb_exc),
    .wb_dbg_cause_o (wb_dbg_cause),
    .wb_exc_cause_o (wb_exc_cause),
    .shift_o        (shift)
  );

  rvfi_retire_formatter u_formatter (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .shift_i           (shift),
    .wb_valid_i        (wb_valid),
    .wb_intr_i         (wb_intr),
    .wb_exc_i          (wb_exc),
    .wb_dbg_cause_i    (wb_dbg_cause),
    .wb_exc_cause_i    (wb_exc_cause),
    .rvfi_valid_o      (rvfi_valid_o),
    .rvfi_intr_o       (rvfi_intr_o),
    .rvfi_trap_o       (rvfi_trap_o),
    .rvfi_dbg_o        (rvfi_dbg_o),
    .rvfi_trap_cause_o (rvfi_trap_cause_o),
    .rvfi_mcause_o     (rvfi_mcause_o)
  );

  // Checker watches the acknowledges against the finished record
  rvfi_sva u_sva (
    .clk_i             (clk_i),
    .rst_ni            (rst_ni),
    .irq_ack_i         (irq_ack_i),
    .dbg_ack_i         (dbg_ack_i),
    .rvfi_valid_i      (rvfi_valid_o),
    .rvfi_intr_i       (rvfi_intr_o),
    .rvfi_trap_i       (rvfi_trap_o),
    .rvfi_dbg_i        (rvfi_dbg_o),
    .rvfi_trap_cause_i (rvfi_trap_cause_o),
    .rvfi_mcause_i     (rvfi_mcause_o)
  );

  rvfi_apb_regs #(
    .CNT_W (CNT_W)
  ) u_apb_regs (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .psel_i        (psel_i),
    .penable_i     (penable_i),
    .pwrite_i      (pwrite_i),
    .paddr_i       (paddr_i),
    .pwdata_i      (pwdata_i),
    .prdata_o      (prdata_o),
    .pready_o      (pready_o),
    .pslverr_o     (pslverr_o),
    .rvfi_valid_i  (rvfi_valid_o),
    .rvfi_intr_i   (rvfi_intr_o),
    .rvfi_dbg_i    (rvfi_dbg_o),
    .rvfi_mcause_i (rvfi_mcause_o)
  );

endmodule

//--- tb_rvfi_trace.sv
// Testbench for the retirement trace unit
// Replays rvfi_patterns.mem, predicts every retirement with a reference
// model, and then reads the statistics back over APB

`timescale 1ns/1ps

module tb_rvfi_trace
  import rvfi_pkg::*;
();

  localparam int N_VEC        = 28;
  localparam int N_WORDS      = N_VEC + 4;
  localparam int DRAIN_CYCLES = 6;
  // Reset, all vectors, the drain and about ten APB accesses of three cycles
  localparam int TIMEOUT_CYCLES = N_VEC + 50;
  localparam logic [EXC_CAUSE_W-1:0] MCAUSE_EXT = 6'h3F;

  logic                   clk;
  logic                   rst_n;
  logic                   stall;
  logic                   instr_valid;
  logic                   exc;
  logic [EXC_CAUSE_W-1:0] exc_cause;
  logic                   irq_ack;
  logic                   dbg_ack;
  logic [DBG_CAUSE_W-1:0] dbg_cause;
  logic                   rvfi_valid;
  logic                   rvfi_intr;
  logic                   rvfi_trap;
  logic [DBG_CAUSE_W-1:0] rvfi_dbg;
  logic [EXC_CAUSE_W-1:0] rvfi_trap_cause;
  logic [EXC_CAUSE_W-1:0] rvfi_mcause;
  logic                   psel;
  logic                   penable;
  logic                   pwrite;
  logic [APB_ADDR_W-1:0]  paddr;
  logic [31:0]            pwdata;
  logic [31:0]            prdata;
  logic                   pready;
  logic                   pslverr;

  logic [31:0] pat [N_WORDS];
  int          cycles = 0;

  // Reference model state with one tag per stage and the pending acknowledges
  logic [NUM_STAGES-1:0]  m_valid;
  logic [NUM_STAGES-1:0]  m_intr;
  logic [NUM_STAGES-1:0]  m_exc;
  logic [DBG_CAUSE_W-1:0] m_dbg [NUM_STAGES];
  logic [EXC_CAUSE_W-1:0] m_cause [NUM_STAGES];
  logic                   irq_pend;
  logic                   dbg_pend;
  logic [DBG_CAUSE_W-1:0] dbg_latched;

  // Expected retirement record and statistics
  logic                   e_valid;
  logic                   e_intr;
  logic                   e_trap;
  logic [DBG_CAUSE_W-1:0] e_dbg;
  logic [EXC_CAUSE_W-1:0] e_tcause;
  logic [EXC_CAUSE_W-1:0] e_mcause;
  int                     c_ret;
  int                     c_intr;
  int                     c_dbg;
  logic [EXC_CAUSE_W-1:0] c_last;

  rvfi_trace_top #(
    .CNT_W (16)
  ) u_rvfi_trace_top (
    .clk_i             (clk),
    .rst_ni            (rst_n),
    .stall_i           (stall),
    .instr_valid_i     (instr_valid),
    .exc_i             (exc),
    .exc_cause_i       (exc_cause),
    .irq_ack_i         (irq_ack),
    .dbg_ack_i         (dbg_ack),
    .dbg_cause_i       (dbg_cause),
    .rvfi_valid_o      (rvfi_valid),
    .rvfi_intr_o       (rvfi_intr),
    .rvfi_trap_o       (rvfi_trap),
    .rvfi_dbg_o        (rvfi_dbg),
    .rvfi_trap_cause_o (rvfi_trap_cause),
    .rvfi_mcause_o     (rvfi_mcause),
    .psel_i            (psel),
    .penable_i         (penable),
    .pwrite_i          (pwrite),
    .paddr_i           (paddr),
    .pwdata_i          (pwdata),
    .prdata_o          (prdata),
    .pready_o          (pready),
    .pslverr_o         (pslverr)
  );

  always #50 clk = ~clk;

  always @(posedge clk) begin
    cycles <= cycles + 1;
    if (cycles >= TIMEOUT_CYCLES) begin
      $display("Timeout: the run went past %0d cycles", TIMEOUT_CYCLES);
      $display("Simulation FAILED");
      $fatal(1, "Run stopped by the cycle limit");
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Checking helpers
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Mismatch at time %0t: %s is 0x%0h, expected 0x%0h",
               $time, what, got, exp);
      $display("Simulation FAILED");
      $fatal(1, "Stopping at the first error");
    end
  endtask

  // Compares the DUT record against the model after the last rising edge
  task automatic check_record();
    check_value("rvfi_valid_o", 32'(rvfi_valid), 32'(e_valid));
    if (e_valid) begin
      check_value("rvfi_intr_o", 32'(rvfi_intr), 32'(e_intr));
      check_value("rvfi_trap_o", 32'(rvfi_trap), 32'(e_trap));
      check_value("rvfi_dbg_o", 32'(rvfi_dbg), 32'(e_dbg));
      check_value("rvfi_mcause_o", 32'(rvfi_mcause), 32'(e_mcause));
      // Trap cause only carries meaning on a trapping retirement
      if (e_trap) check_value("rvfi_trap_cause_o", 32'(rvfi_trap_cause), 32'(e_tcause));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus and reference model
  ////////////////////////////////////////////////////////////////////////////

  // One hex digit per field, cause in two digits
  task automatic apply_vector(input logic [31:0] vec);
    stall       = vec[28];
    instr_valid = vec[24];
    exc         = vec[20];
    exc_cause   = vec[17:12];
    irq_ack     = vec[8];
    dbg_ack     = vec[4];
    dbg_cause   = vec[2:0];
  endtask

  // Advances the model over the coming rising edge with the driven inputs
  task automatic step_model();
    logic shift;
    logic enter;
    logic retire;
    logic prev_trap;
    shift  = !stall;
    enter  = shift && instr_valid;
    retire = shift && m_valid[STAGE_WB];
    // Statistics count the record that is visible right now
    if (e_valid) begin
      c_ret++;
      if (e_intr) begin
        c_intr++;
        c_last = e_mcause;
      end
      if (e_dbg != DBG_CAUSE_NONE) c_dbg++;
    end
    e_valid = retire;
    if (retire) begin
      prev_trap = e_trap;
      // Handler entry after a trap reports that trap's cause
      if (prev_trap) e_mcause = e_tcause;
      else if (m_intr[STAGE_WB]) e_mcause = MCAUSE_EXT;
      e_intr   = m_intr[STAGE_WB] || prev_trap;
      e_trap   = m_exc[STAGE_WB];
      e_tcause = m_exc[STAGE_WB] ? m_cause[STAGE_WB] : '0;
      e_dbg    = m_dbg[STAGE_WB];
    end
    if (shift) begin
      for (int s = NUM_STAGES - 1; s > 0; s--) begin
        m_valid[s] = m_valid[s-1];
        m_intr[s]  = m_intr[s-1];
        m_exc[s]   = m_exc[s-1];
        m_dbg[s]   = m_dbg[s-1];
        m_cause[s] = m_cause[s-1];
      end
      m_valid[STAGE_IF] = instr_valid;
      m_intr[STAGE_IF]  = enter && (irq_ack || irq_pend);
      m_exc[STAGE_IF]   = enter && exc;
      m_cause[STAGE_IF] = exc_cause;
      if (!enter) m_dbg[STAGE_IF] = DBG_CAUSE_NONE;
      else if (dbg_ack) m_dbg[STAGE_IF] = dbg_cause;
      else if (dbg_pend) m_dbg[STAGE_IF] = dbg_latched;
      else m_dbg[STAGE_IF] = DBG_CAUSE_NONE;
    end
    if (enter) begin
      irq_pend = 1'b0;
      dbg_pend = 1'b0;
    end else begin
      if (irq_ack) irq_pend = 1'b1;
      if (dbg_ack) dbg_pend = 1'b1;
    end
    if (dbg_ack) dbg_latched = dbg_cause;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // APB master
  ////////////////////////////////////////////////////////////////////////////

  task automatic apb_access(input logic wr, input logic [APB_ADDR_W-1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata,
                            output logic err);
    @(negedge clk);
    psel    = 1'b1;
    penable = 1'b0;
    pwrite  = wr;
    paddr   = addr;
    pwdata  = wdata;
    @(negedge clk);
    penable = 1'b1;
    #10;
    // The slave has no wait states, so the access phase completes at once
    check_value("pready", 32'(pready), 32'h1);
    rdata = prdata;
    err   = pslverr;
    @(negedge clk);
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
  endtask

  task automatic read_register(input string name, input logic [APB_ADDR_W-1:0] addr,
                               input logic [31:0] exp);
    logic [31:0] rd;
    logic        err;
    apb_access(1'b0, addr, 32'h0, rd, err);
    check_value({name, " pslverr"}, 32'(err), 32'h0);
    check_value(name, rd, exp);
  endtask

  task automatic read_all_registers();
    read_register("REG_RETIRED", REG_RETIRED, 32'(c_ret));
    read_register("REG_INTR", REG_INTR, 32'(c_intr));
    read_register("REG_DBG", REG_DBG, 32'(c_dbg));
    read_register("REG_CAUSE", REG_CAUSE, 32'(c_last));
  endtask

  initial begin
    logic [31:0] rd;
    logic        err;
    clk     = 1'b0;
    rst_n   = 1'b0;
    psel    = 1'b0;
    penable = 1'b0;
    pwrite  = 1'b0;
    paddr   = '0;
    pwdata  = '0;
    apply_vector(32'h0);
    m_valid     = '0;
    m_intr      = '0;
    m_exc       = '0;
    irq_pend    = 1'b0;
    dbg_pend    = 1'b0;
    dbg_latched = DBG_CAUSE_NONE;
    for (int s = 0; s < NUM_STAGES; s++) begin
      m_dbg[s]   = DBG_CAUSE_NONE;
      m_cause[s] = '0;
    end
    e_valid  = 1'b0;
    e_intr   = 1'b0;
    e_trap   = 1'b0;
    e_dbg    = DBG_CAUSE_NONE;
    e_tcause = '0;
    e_mcause = '0;
    c_ret    = 0;
    c_intr   = 0;
    c_dbg    = 0;
    c_last   = '0;
    $readmemh("rvfi_patterns.mem", pat);

    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Each falling edge checks the last record and drives the next vector
    for (int i = 0; i < N_VEC; i++) begin
      check_record();
      apply_vector(pat[i]);
      step_model();
      @(negedge clk);
    end
    for (int i = 0; i < DRAIN_CYCLES; i++) begin
      check_record();
      apply_vector(32'h0);
      step_model();
      @(negedge clk);
    end
    check_record();

    // The pattern file and the model have to agree on the totals
    check_value("retired total in patterns", pat[N_VEC], 32'(c_ret));
    check_value("interrupt total in patterns", pat[N_VEC+1], 32'(c_intr));
    check_value("debug total in patterns", pat[N_VEC+2], 32'(c_dbg));
    check_value("last mcause in patterns", pat[N_VEC+3], 32'(c_last));
    read_all_registers();

    apb_access(1'b1, REG_RETIRED, 32'hFFFF_FFFF, rd, err);
    check_value("pslverr on write", 32'(err), 32'h1);
    apb_access(1'b0, 4'h2, 32'h0, rd, err);
    check_value("pslverr on unmapped read", 32'(err), 32'h1);
    read_all_registers();

    $display("Simulation PASSED");
    $finish;
  end

endmodule
